/* gateway_tag_ctrl.f */
+incdir+verilog
verilog/gateway_tag_pkg.sv
verilog/gateway_tag_master.sv
verilog/gateway_tag_client.sv
verilog/gateway_reset_sequencer.sv
verilog/gateway_tag_ctrl.sv
tests/gateway_tag_ctrl_tb.sv

/* tests/gateway_tag_ctrl_tb.sv */
`timescale 1ns/100ps
`include "gateway_tag_cfg.svh"

module gateway_tag_ctrl_tb;

  import gateway_tag_pkg::*;

  localparam int    pkt_bits_lp     = 1 + `GW_TAG_ID_W + `GW_TAG_PAYLOAD_W;
  localparam int    no_packet_lp    = 'hff;
  localparam string pattern_file_lp = "tests/gateway_tag_patterns.txt";

  logic                      clk;
  logic                      rst_n;
  logic                      tag_en;
  logic                      tag_data;
  logic                      trace_done;
  logic                      core_reset;
  logic                      host_reset;
  logic [`GW_HOST_DID_W-1:0] my_cord;
  logic [`GW_CORE_DID_W-1:0] dst_cord;
  logic                      cfg_skip;
  logic                      link_up;

  // One entry per pattern line
  // exp_q holds six expected values per line
  string name_q[$];
  int    id_q[$];
  int    payload_q[$];
  int    trace_q[$];
  int    abort_q[$];
  int    exp_q[$];

  int                cycle_cnt   = 0;
  int                cycle_limit = 0;
  tag_master_state_t stuck_state;

  gateway_tag_ctrl dut
    (.clk_i           (clk)
    ,.rst_n_i         (rst_n)
    ,.tag_en_i        (tag_en)
    ,.tag_data_i      (tag_data)
    ,.trace_done_i    (trace_done)
    ,.core_reset_o    (core_reset)
    ,.host_reset_o    (host_reset)
    ,.host_my_cord_o  (my_cord)
    ,.host_dst_cord_o (dst_cord)
    ,.cfg_skip_o      (cfg_skip)
    ,.link_up_o       (link_up)
    );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Failure handling

  task automatic end_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_output(input string test, input string sig,
                              input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp)
    else
    begin
      $display("** Error [%s] %s expected %0h, actual %0h", test, sig, exp, act);
      end_with_failure();
    end
  endtask

  // Hung run guard with a limit set after loading the patterns
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      stuck_state = dut.master.state_q;
      $display("Timeout after %0d cycles with the tag master in state %s",
               cycle_cnt, stuck_state.name());
      end_with_failure();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pattern file and packet building

  task automatic load_patterns();
    int    fd;
    int    cnt;
    string line;
    string name;
    int    id, payload, td, abort;
    int    cr, hr, my, dst, skip, link;
    fd = $fopen(pattern_file_lp, "r");
    if (fd == 0)
    begin
      $display("Could not open the pattern file %s", pattern_file_lp);
      end_with_failure();
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        // Skip blank lines and column notes
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          cnt = $sscanf(line, "%s %h %h %d %d %d %d %h %h %d %d", name, id, payload,
                        td, abort, cr, hr, my, dst, skip, link);
          if (cnt != 11)
          begin
            $display("Pattern line could not be parsed: %s", line);
            end_with_failure();
          end
          else
          begin
            name_q.push_back(name);
            id_q.push_back(id);
            payload_q.push_back(payload);
            trace_q.push_back(td);
            abort_q.push_back(abort);
            exp_q.push_back(cr);
            exp_q.push_back(hr);
            exp_q.push_back(my);
            exp_q.push_back(dst);
            exp_q.push_back(skip);
            exp_q.push_back(link);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Start bit followed by the ID and payload, both LSB first
  function automatic logic [pkt_bits_lp-1:0] build_packet(input int id, input int payload);
    logic [pkt_bits_lp-1:0] bits;
    bits[0] = 1'b1;
    for (int i = 0; i < `GW_TAG_ID_W; i++)
      bits[1+i] = id[i];
    for (int i = 0; i < `GW_TAG_PAYLOAD_W; i++)
      bits[1+`GW_TAG_ID_W+i] = payload[i];
    return bits;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // One pattern line

  task automatic run_step(input int idx);
    logic [pkt_bits_lp-1:0] bits;
    int                     n;
    int                     gap;
    string                  name;
    name = name_q[idx];
    @(posedge clk);
    trace_done <= trace_q[idx][0];
    if (id_q[idx] != no_packet_lp)
    begin
      bits = build_packet(id_q[idx], payload_q[idx]);
      n    = (abort_q[idx] != 0) ? abort_q[idx] : pkt_bits_lp;
      for (int b = 0; b < n; b++)
      begin
        @(posedge clk);
        tag_en   <= 1'b1;
        tag_data <= bits[b];
      end
      // Enable drop here also aborts a short packet
      @(posedge clk);
      tag_en   <= 1'b0;
      tag_data <= 1'b0;
    end
    gap = 6 + ($urandom % 8);
    repeat (gap) @(posedge clk);
    @(negedge clk);
    check_output(name, "core_reset_o", exp_q[idx*6+0], core_reset);
    check_output(name, "host_reset_o", exp_q[idx*6+1], host_reset);
    check_output(name, "host_my_cord_o", exp_q[idx*6+2], my_cord);
    check_output(name, "host_dst_cord_o", exp_q[idx*6+3], dst_cord);
    check_output(name, "cfg_skip_o", exp_q[idx*6+4], cfg_skip);
    check_output(name, "link_up_o", exp_q[idx*6+5], link_up);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    tag_en     = 1'b0;
    tag_data   = 1'b0;
    trace_done = 1'b0;
    void'($urandom(59187));
    load_patterns();
    cycle_limit = 8 + name_q.size() * 30;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < name_q.size(); i++)
      run_step(i);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* tests/gateway_tag_patterns.txt */
# name id(hex, ff = idle only) payload(hex) trace_done abort(bits sent, 0 = full packet)
# then expected: core_reset host_reset my_cord(hex) dst_cord(hex) cfg_skip link_up
reset_state          ff 00 0 0  1 1 0 0 0 0
core_pre_trace       0  0a 0 0  1 1 0 a 0 0
host_pre_trace       1  0b 0 0  1 1 5 a 1 0
bring_up             ff 00 1 0  0 0 5 a 1 1
core_new_did         0  03 1 0  0 0 5 3 1 1
unknown_id_5         5  1f 1 0  0 0 5 3 1 1
unknown_id_f         f  15 1 0  0 0 5 3 1 1
abort_host_payload   1  1e 1 7  0 0 5 3 1 1
abort_core_payload   0  10 1 9  0 0 5 3 1 1
abort_in_id          1  1f 1 3  0 0 5 3 1 1
host_after_abort     1  0c 1 0  0 0 6 3 0 1
core_after_abort     0  07 1 0  0 0 6 7 0 1
core_reset_set       0  17 1 0  1 0 6 7 0 0
core_reset_clear     0  09 1 0  0 0 6 9 0 1
host_reset_set       1  1d 1 0  0 1 6 9 1 0
trace_drop           ff 00 0 0  1 1 6 9 1 0
host_clear_no_trace  1  04 0 0  1 1 2 9 0 0
trace_back           ff 00 1 0  0 0 2 9 0 1

/* verilog/gateway_reset_sequencer.sv */
`timescale 1ns/100ps
`include "gateway_tag_cfg.svh"

module gateway_reset_sequencer
  (input  logic                              clk_i
  ,input  logic                              rst_n_i
  ,input  logic                              trace_done_i

  ,input  gateway_tag_pkg::core_tag_payload_t core_payload_i
  ,input  logic                              core_new_i

  ,input  gateway_tag_pkg::host_tag_payload_t host_payload_i
  ,input  logic                              host_new_i

  ,output logic                              core_reset_o
  ,output logic                              host_reset_o
  ,output logic [`GW_HOST_DID_W-1:0]         host_my_cord_o
  ,output logic [`GW_CORE_DID_W-1:0]         host_dst_cord_o
  ,output logic                              cfg_skip_o
  ,output logic                              link_up_o
  );

  logic core_seen_q, host_seen_q;
  logic core_seen, host_seen;
  logic core_reset_n, host_reset_n;

  ////////////////////////////////////////////////////////////////////////////
  // Client presence

  // A new pulse counts as seen in the same cycle
  assign core_seen = core_seen_q | core_new_i;
  assign host_seen = host_seen_q | host_new_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      core_seen_q <= 1'b0;
      host_seen_q <= 1'b0;
    end
    else
    begin
      core_seen_q <= core_seen;
      host_seen_q <= host_seen;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Node resets and link status

  // Held in reset until the trace is done and the node has been configured
  assign core_reset_n = core_payload_i.reset | ~trace_done_i | ~core_seen;
  assign host_reset_n = host_payload_i.reset | ~trace_done_i | ~host_seen;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      core_reset_o    <= 1'b1;
      host_reset_o    <= 1'b1;
      host_my_cord_o  <= '0;
      host_dst_cord_o <= '0;
      cfg_skip_o      <= 1'b0;
      link_up_o       <= 1'b0;
    end
    else
    begin
      core_reset_o    <= core_reset_n;
      host_reset_o    <= host_reset_n;
      host_my_cord_o  <= host_payload_i.did;
      host_dst_cord_o <= core_payload_i.did;
      cfg_skip_o      <= host_payload_i.cfg_skip;
      link_up_o       <= ~core_reset_n & ~host_reset_n;
    end
  end

endmodule

/* verilog/gateway_tag_cfg.svh */
`ifndef GATEWAY_TAG_CFG_SVH
`define GATEWAY_TAG_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Packet format

// Client ID field, sent LSB first after the start bit
`define GW_TAG_ID_W 4

// Every packet carries exactly this many payload bits
`define GW_TAG_PAYLOAD_W 5

////////////////////////////////////////////////////////////////////////////
// Node coordinates and client map

`define GW_CORE_DID_W 4
`define GW_HOST_DID_W 3

`define GW_CORE_CLIENT_ID 0
`define GW_HOST_CLIENT_ID 1
`define GW_NUM_CLIENTS    2

`endif

/* verilog/gateway_tag_client.sv */
`timescale 1ns/100ps

module gateway_tag_client
  #(parameter type payload_t = logic [4:0])
  (input  logic     clk_i
  ,input  logic     rst_n_i
  ,input  logic     tag_bit_i
  ,input  logic     shift_i
  ,input  logic     commit_i
  ,output payload_t payload_o
  ,output logic     new_o
  );

  localparam int width_lp = $bits(payload_t);

  logic [width_lp-1:0] shift_q;

  ////////////////////////////////////////////////////////////////////////////
  // Receive shifter

  // LSB arrives first, so bits move down from the top
  always_ff @(posedge clk_i)
  begin
    if (shift_i)
      shift_q <= {tag_bit_i, shift_q[width_lp-1:1]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Committed word

  // Only a complete packet reaches the output
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      payload_o <= '0;
      new_o     <= 1'b0;
    end
    else
    begin
      new_o <= commit_i;
      if (commit_i)
        payload_o <= payload_t'(shift_q);
    end
  end

endmodule

/* verilog/gateway_tag_ctrl.sv */
`timescale 1ns/100ps
`include "gateway_tag_cfg.svh"

module gateway_tag_ctrl
  (input  logic                      clk_i
  ,input  logic                      rst_n_i
  ,input  logic                      tag_en_i
  ,input  logic                      tag_data_i
  ,input  logic                      trace_done_i

  ,output logic                      core_reset_o
  ,output logic                      host_reset_o
  ,output logic [`GW_HOST_DID_W-1:0] host_my_cord_o
  ,output logic [`GW_CORE_DID_W-1:0] host_dst_cord_o
  ,output logic                      cfg_skip_o
  ,output logic                      link_up_o
  );

  import gateway_tag_pkg::*;

  logic                       tag_bit_lo;
  logic [`GW_NUM_CLIENTS-1:0] shift_lo;
  logic [`GW_NUM_CLIENTS-1:0] commit_lo;

  core_tag_payload_t core_payload_lo;
  logic              core_new_lo;
  host_tag_payload_t host_payload_lo;
  logic              host_new_lo;

  ////////////////////////////////////////////////////////////////////////////
  // Tag master

  gateway_tag_master master
    (.clk_i      (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.tag_en_i   (tag_en_i)
    ,.tag_data_i (tag_data_i)
    ,.tag_bit_o  (tag_bit_lo)
    ,.shift_o    (shift_lo)
    ,.commit_o   (commit_lo)
    );

  ////////////////////////////////////////////////////////////////////////////
  // Tag clients

  gateway_tag_client #(.payload_t(core_tag_payload_t)) core_client
    (.clk_i     (clk_i)
    ,.rst_n_i   (rst_n_i)
    ,.tag_bit_i (tag_bit_lo)
    ,.shift_i   (shift_lo[`GW_CORE_CLIENT_ID])
    ,.commit_i  (commit_lo[`GW_CORE_CLIENT_ID])
    ,.payload_o (core_payload_lo)
    ,.new_o     (core_new_lo)
    );

  gateway_tag_client #(.payload_t(host_tag_payload_t)) host_client
    (.clk_i     (clk_i)
    ,.rst_n_i   (rst_n_i)
    ,.tag_bit_i (tag_bit_lo)
    ,.shift_i   (shift_lo[`GW_HOST_CLIENT_ID])
    ,.commit_i  (commit_lo[`GW_HOST_CLIENT_ID])
    ,.payload_o (host_payload_lo)
    ,.new_o     (host_new_lo)
    );

  ////////////////////////////////////////////////////////////////////////////
  // Reset sequencing

  gateway_reset_sequencer sequencer
    (.clk_i           (clk_i)
    ,.rst_n_i         (rst_n_i)
    ,.trace_done_i    (trace_done_i)
    ,.core_payload_i  (core_payload_lo)
    ,.core_new_i      (core_new_lo)
    ,.host_payload_i  (host_payload_lo)
    ,.host_new_i      (host_new_lo)
    ,.core_reset_o    (core_reset_o)
    ,.host_reset_o    (host_reset_o)
    ,.host_my_cord_o  (host_my_cord_o)
    ,.host_dst_cord_o (host_dst_cord_o)
    ,.cfg_skip_o      (cfg_skip_o)
    ,.link_up_o       (link_up_o)
    );

endmodule

/* verilog/gateway_tag_master.sv */
`timescale 1ns/100ps
`include "gateway_tag_cfg.svh"

module gateway_tag_master
  (input  logic                       clk_i
  ,input  logic                       rst_n_i
  ,input  logic                       tag_en_i
  ,input  logic                       tag_data_i
  ,output logic                       tag_bit_o
  ,output logic [`GW_NUM_CLIENTS-1:0] shift_o
  ,output logic [`GW_NUM_CLIENTS-1:0] commit_o
  );

  import gateway_tag_pkg::*;

  localparam int cnt_max_lp = (`GW_TAG_PAYLOAD_W > `GW_TAG_ID_W)
                              ? `GW_TAG_PAYLOAD_W : `GW_TAG_ID_W;
  localparam int cnt_w_lp   = $clog2(cnt_max_lp);

  tag_master_state_t          state_q, state_n;
  logic [cnt_w_lp-1:0]        cnt_q, cnt_n;
  logic [`GW_TAG_ID_W-1:0]    id_q;
  logic [`GW_TAG_ID_W-1:0]    id_full;
  logic [`GW_NUM_CLIENTS-1:0] sel_q, sel_n;
  logic [`GW_NUM_CLIENTS-1:0] shift_n, commit_n;
  logic                       last_q, last_n;
  logic                       id_done, payload_done;

  // Client i answers to ID i, anything else selects nobody
  function automatic logic [`GW_NUM_CLIENTS-1:0] decode_id
    (input logic [`GW_TAG_ID_W-1:0] id);
    logic [`GW_NUM_CLIENTS-1:0] hot;
    hot = '0;
    for (int i = 0; i < `GW_NUM_CLIENTS; i++)
    begin
      if (int'(id) == i)
        hot[i] = 1'b1;
    end
    return hot;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Packet FSM

  // Full ID including the bit arriving this cycle
  assign id_full      = {tag_data_i, id_q[`GW_TAG_ID_W-1:1]};
  assign id_done      = (cnt_q == cnt_w_lp'(`GW_TAG_ID_W - 1));
  assign payload_done = (cnt_q == cnt_w_lp'(`GW_TAG_PAYLOAD_W - 1));

  always_comb
  begin
    state_n = state_q;
    cnt_n   = cnt_q;
    sel_n   = sel_q;
    last_n  = 1'b0;
    case (state_q)
      IDLE:
      begin
        cnt_n = '0;
        if (tag_en_i && tag_data_i)
          state_n = ID;
      end
      ID:
      begin
        if (!tag_en_i)
          state_n = IDLE;
        else if (id_done)
        begin
          state_n = PAYLOAD;
          cnt_n   = '0;
          sel_n   = decode_id(id_full);
        end
        else
          cnt_n = cnt_q + 1'b1;
      end
      PAYLOAD:
      begin
        // Enable drop aborts, last_n stays low so nothing commits
        if (!tag_en_i)
          state_n = IDLE;
        else if (payload_done)
        begin
          state_n = IDLE;
          last_n  = 1'b1;
        end
        else
          cnt_n = cnt_q + 1'b1;
      end
      default:
        state_n = IDLE;
    endcase
  end

  assign shift_n  = (state_q == PAYLOAD && tag_en_i) ? sel_q : '0;
  assign commit_n = last_q ? sel_q : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      sel_q    <= '0;
      last_q   <= 1'b0;
      shift_o  <= '0;
      commit_o <= '0;
    end
    else
    begin
      state_q  <= state_n;
      cnt_q    <= cnt_n;
      sel_q    <= sel_n;
      last_q   <= last_n;
      shift_o  <= shift_n;
      commit_o <= commit_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == ID && tag_en_i)
      id_q <= id_full;
    if (state_q == PAYLOAD && tag_en_i)
      tag_bit_o <= tag_data_i;
  end

endmodule

/* verilog/gateway_tag_pkg.sv */
`include "gateway_tag_cfg.svh"

package gateway_tag_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Client payloads

  // First declared field is the MSB, so reset is the last bit on the wire
  typedef struct packed
  {
    logic                      reset;
    logic [`GW_CORE_DID_W-1:0] did;
  } core_tag_payload_t;

  // Host node also carries the skip-init flag in bit 0
  typedef struct packed
  {
    logic                      reset;
    logic [`GW_HOST_DID_W-1:0] did;
    logic                      cfg_skip;
  } host_tag_payload_t;

  ////////////////////////////////////////////////////////////////////////////
  // Tag master FSM

  // IDLE waits for a start bit
  // ID collects the client ID
  // PAYLOAD steers data bits to the selected client
  typedef enum logic [1:0]
  {
    IDLE,
    ID,
    PAYLOAD
  } tag_master_state_t;

endpackage
